// ==== project.f ====
+incdir+hdl
+incdir+verif
hdl/bp_store_pkg.sv
hdl/bp_stage_pkg.sv
hdl/bp_table.sv
hdl/gshare_pht.sv
hdl/btb.sv
hdl/fetch_pc_unit.sv
hdl/gshare_fetch_top.sv
verif/tb_gshare_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_gshare_fetch
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_gshare_vectors.svh ====
`ifndef TB_GSHARE_VECTORS_SVH
`define TB_GSHARE_VECTORS_SVH

// Columns: fetch_en, kind, res pc, res target, taken, pred_taken, res ghr,
//          exp pc, exp hit, exp taken, exp target, exp ghr, exp flush
task automatic load_vectors();
    // Reset state and sequential fetch with stalls
    add_row(1, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h000, 0, 0, 32'h000, 8'h00, 0);
    add_row(1, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h004, 0, 0, 32'h000, 8'h00, 0);
    add_row(0, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h008, 0, 0, 32'h000, 8'h00, 0);
    add_row(0, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h008, 0, 0, 32'h000, 8'h00, 0);
    add_row(1, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h008, 0, 0, 32'h000, 8'h00, 0);
    // Taken branch predicted not taken
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 0, 8'h00, 32'h00c, 0, 0, 32'h000, 8'h00, 1);
    add_row(0, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h400, 0, 0, 32'h000, 8'h01, 0);
    // Not-taken branch predicted taken
    add_row(0, RES_COND, 32'h200, 32'h300, 0, 1, 8'h01, 32'h400, 0, 0, 32'h000, 8'h01, 1);
    add_row(1, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h204, 0, 0, 32'h000, 8'h02, 0);
    // Indirect jump, history untouched
    add_row(1, RES_JALR, 32'h500, 32'h600, 1, 1, 8'h02, 32'h208, 0, 0, 32'h000, 8'h02, 1);
    add_row(0, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h600, 0, 0, 32'h000, 8'h02, 0);
    // Fill the history with taken outcomes
    add_row(0, RES_JAL,  32'h100, 32'h400, 1, 1, 8'h02, 32'h600, 0, 0, 32'h000, 8'h02, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'h05, 32'h600, 0, 0, 32'h000, 8'h05, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'h0b, 32'h600, 0, 0, 32'h000, 8'h0b, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'h17, 32'h600, 0, 0, 32'h000, 8'h17, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'h2f, 32'h600, 0, 0, 32'h000, 8'h2f, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'h5f, 32'h600, 0, 0, 32'h000, 8'h5f, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'hbf, 32'h600, 0, 0, 32'h000, 8'hbf, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'h7f, 32'h600, 0, 0, 32'h000, 8'h7f, 0);
    // Train the counter under all-ones history, then jump to the branch
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'hff, 32'h600, 0, 0, 32'h000, 8'hff, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'hff, 32'h600, 0, 0, 32'h000, 8'hff, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 1, 1, 8'hff, 32'h600, 0, 0, 32'h000, 8'hff, 0);
    add_row(0, RES_JALR, 32'h104, 32'h100, 1, 0, 8'hff, 32'h600, 0, 0, 32'h000, 8'hff, 1);
    add_row(1, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h100, 1, 1, 32'h400, 8'hff, 0);
    add_row(0, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h400, 0, 0, 32'h000, 8'hff, 0);
    // Saturation, the counter is seen again through an aliased fetch index
    add_row(0, RES_COND, 32'h100, 32'h400, 0, 1, 8'hff, 32'h400, 0, 0, 32'h000, 8'hff, 1);
    add_row(0, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h104, 1, 1, 32'h100, 8'hfe, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 0, 0, 8'hff, 32'h104, 1, 1, 32'h100, 8'hfe, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 0, 0, 8'hff, 32'h104, 1, 0, 32'h100, 8'hfc, 0);
    add_row(0, RES_COND, 32'h100, 32'h400, 0, 0, 8'hff, 32'h104, 1, 0, 32'h100, 8'hf8, 0);
    add_row(0, RES_JALR, 32'h13c, 32'h13c, 1, 1, 8'hf0, 32'h104, 1, 0, 32'h100, 8'hf0, 1);
    add_row(0, RES_NONE, 32'h000, 32'h000, 0, 0, 8'h00, 32'h13c, 1, 0, 32'h13c, 8'hf0, 0);
endtask

`endif

// ==== verif/tb_gshare_fetch.sv ====
`timescale 1ns/1ps

module tb_gshare_fetch;

    import bp_store_pkg::*;
    import bp_stage_pkg::*;

    localparam int RESET_TIMEOUT = 20;

    typedef struct packed {
        logic     fetch_en;
        resolve_t res;
        pc_t      exp_pc;
        pred_t    exp_pred;
        logic     exp_flush;
    } vec_t;

    logic     clk_i;
    logic     rst_ni;
    logic     fetch_en_i;
    resolve_t resolve_i;
    pc_t      fetch_pc_o;
    pred_t    pred_o;
    logic     flush_o;

    vec_t vectors[$];

    gshare_fetch_top u_gshare_fetch_top (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .fetch_en_i (fetch_en_i),
        .resolve_i  (resolve_i),
        .fetch_pc_o (fetch_pc_o),
        .pred_o     (pred_o),
        .flush_o    (flush_o)
    );

    task automatic add_row(input logic en, input resolve_kind_t kind, input pc_t rpc,
                           input pc_t rtgt, input logic tk, input logic ptk,
                           input ghr_t rghr, input pc_t epc, input logic ehit,
                           input logic etk, input pc_t etgt, input ghr_t eghr,
                           input logic eflush);
        vec_t v;
        v.fetch_en       = en;
        v.res.kind       = kind;
        v.res.pc         = rpc;
        v.res.target     = rtgt;
        v.res.taken      = tk;
        v.res.pred_taken = ptk;
        v.res.ghr        = rghr;
        v.exp_pc         = epc;
        v.exp_pred.hit   = ehit;
        v.exp_pred.taken = etk;
        v.exp_pred.target = etgt;
        v.exp_pred.ghr   = eghr;
        v.exp_flush      = eflush;
        vectors.push_back(v);
    endtask

    `include "tb_gshare_vectors.svh"

    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_pred(input string name, input pred_t got, input pred_t exp);
        if (got !== exp) begin
            $write("mismatch at %0t: %s got hit=%b taken=%b target=%h ghr=%h",
                   $time, name, got.hit, got.taken, got.target, got.ghr);
            $display(" expected hit=%b taken=%b target=%h ghr=%h",
                     exp.hit, exp.taken, exp.target, exp.ghr);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Reset held for five cycles, released just after an edge
    initial begin
        rst_ni     = 1'b0;
        fetch_en_i = 1'b0;
        resolve_i  = '0;
        repeat (5) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;
    end

    initial begin
        int cycles;
        cycles = 0;
        load_vectors();
        while (rst_ni !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (rst_ni !== 1'b1) begin
            $display("Reset was never released within %0d cycles", RESET_TIMEOUT);
            report_failure();
        end
        foreach (vectors[i]) begin
            @(posedge clk_i);
            #5;
            fetch_en_i = vectors[i].fetch_en;
            resolve_i  = vectors[i].res;
            // Sample just before the next rising edge
            #90;
            check_pc("fetch_pc_o", fetch_pc_o, vectors[i].exp_pc);
            check_pred("pred_o", pred_o, vectors[i].exp_pred);
            check_flag("flush_o", flush_o, vectors[i].exp_flush);
        end
        @(posedge clk_i);
        #5;
        fetch_en_i = 1'b0;
        resolve_i  = '0;
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== hdl/gshare_fetch_top.sv ====
`timescale 1ns/1ps

module gshare_fetch_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   fetch_en_i,
    input  bp_stage_pkg::resolve_t resolve_i,
    output bp_store_pkg::pc_t      fetch_pc_o,
    output bp_stage_pkg::pred_t    pred_o,
    output logic                   flush_o
);

    import bp_store_pkg::*;
    import bp_stage_pkg::*;

    pc_t  fetch_pc;
    pc_t  btb_target;
    ghr_t ghr;
    logic btb_hit;
    logic pht_taken;

    gshare_pht u_gshare_pht (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .fetch_pc_i (fetch_pc),
        .resolve_i  (resolve_i),
        .taken_o    (pht_taken),
        .ghr_o      (ghr)
    );

    btb u_btb (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .fetch_pc_i (fetch_pc),
        .resolve_i  (resolve_i),
        .hit_o      (btb_hit),
        .target_o   (btb_target)
    );

    // Taken needs both a known target and a taken counter
    assign pred_o.hit    = btb_hit;
    assign pred_o.taken  = btb_hit && pht_taken;
    assign pred_o.target = btb_target;
    assign pred_o.ghr    = ghr;

    fetch_pc_unit u_fetch_pc_unit (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_en_i    (fetch_en_i),
        .resolve_i     (resolve_i),
        .pred_taken_i  (pred_o.taken),
        .pred_target_i (pred_o.target),
        .pc_o          (fetch_pc),
        .flush_o       (flush_o)
    );

    assign fetch_pc_o = fetch_pc;

endmodule

// ==== hdl/fetch_pc_unit.sv ====
`timescale 1ns/1ps
`include "bp_cfg.svh"

module fetch_pc_unit (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   fetch_en_i,
    input  bp_stage_pkg::resolve_t resolve_i,
    input  logic                   pred_taken_i,
    input  bp_store_pkg::pc_t      pred_target_i,
    output bp_store_pkg::pc_t      pc_o,
    output logic                   flush_o
);

    import bp_store_pkg::*;
    import bp_stage_pkg::*;

    pc_t  pc_q;
    pc_t  pc_next;
    pc_t  pc_plus4;
    pc_t  predict_pc;
    pc_t  recover_pc;
    logic direction_kind;
    logic mispredict;
    logic pc_load;

    assign direction_kind = (resolve_i.kind == RES_COND) || (resolve_i.kind == RES_JAL);

    // Direction mismatch, or an indirect jump whose target is never trusted
    assign mispredict = (direction_kind && (resolve_i.pred_taken != resolve_i.taken))
                        || (resolve_i.kind == RES_JALR);

    assign pc_plus4   = pc_q + pc_t'(4);
    assign predict_pc = pred_taken_i ? pred_target_i : pc_plus4;
    assign recover_pc = resolve_i.taken ? resolve_i.target : resolve_i.pc + pc_t'(4);

    // Recovery wins over the fetch enable
    always_comb begin
        if (mispredict) begin
            pc_next = recover_pc;
        end else begin
            pc_next = predict_pc;
        end
    end

    assign pc_load = mispredict || fetch_en_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= pc_t'(`BP_RESET_PC);
        end else if (pc_load) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o    = pc_q;
    assign flush_o = mispredict;

endmodule

// ==== hdl/btb.sv ====
`timescale 1ns/1ps
`include "bp_cfg.svh"

module btb (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  bp_store_pkg::pc_t      fetch_pc_i,
    input  bp_stage_pkg::resolve_t resolve_i,
    output logic                   hit_o,
    output bp_store_pkg::pc_t      target_o
);

    import bp_store_pkg::*;
    import bp_stage_pkg::*;

    localparam int IW = `BP_INDEX_WIDTH;
    localparam int XW = `BP_XLEN;

    logic [1:0][IW-1:0] rd_idx;
    btb_entry_t [1:0]   rd_entry;
    btb_entry_t         wr_entry;
    btb_tag_t           fetch_tag;
    logic               alloc;

    assign fetch_tag = fetch_pc_i[XW-1:IW+2];
    assign rd_idx[0] = fetch_pc_i[IW+1:2];
    assign rd_idx[1] = resolve_i.pc[IW+1:2];

    assign wr_entry.valid  = 1'b1;
    assign wr_entry.tag    = resolve_i.pc[XW-1:IW+2];
    assign wr_entry.target = resolve_i.target;

    // Any taken resolve allocates, skip the write if the entry already matches
    assign alloc = (resolve_i.kind != RES_NONE) && resolve_i.taken
                   && (rd_entry[1] != wr_entry);

    bp_table #(
        .entry_t     (btb_entry_t),
        .DEPTH_LOG2  (IW),
        .RESET_VALUE (btb_entry_t'('0))
    ) u_btb_table (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rd_entry),
        .wr_en_i   (alloc),
        .wr_idx_i  (rd_idx[1]),
        .wr_data_i (wr_entry)
    );

    assign hit_o    = rd_entry[0].valid && (rd_entry[0].tag == fetch_tag);
    assign target_o = rd_entry[0].target;

endmodule

// ==== hdl/gshare_pht.sv ====
`timescale 1ns/1ps
`include "bp_cfg.svh"

module gshare_pht (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  bp_store_pkg::pc_t      fetch_pc_i,
    input  bp_stage_pkg::resolve_t resolve_i,
    output logic                   taken_o,
    output bp_store_pkg::ghr_t     ghr_o
);

    import bp_store_pkg::*;
    import bp_stage_pkg::*;

    localparam int HW = `BP_HISTORY_WIDTH;

    ghr_t               ghr_q;
    logic               train;
    logic [1:0][HW-1:0] rd_idx;
    counter_t [1:0]     rd_cnt;
    counter_t           cnt_next;

    // Only conditional branches and direct jumps carry history
    assign train = (resolve_i.kind == RES_COND) || (resolve_i.kind == RES_JAL);

    // gshare index: PC word bits folded with history
    assign rd_idx[0] = fetch_pc_i[HW+1:2] ^ ghr_q;
    assign rd_idx[1] = resolve_i.pc[HW+1:2] ^ resolve_i.ghr;

    // Saturating update of the counter seen at fetch time
    always_comb begin
        cnt_next = rd_cnt[1];
        if (resolve_i.taken) begin
            if (rd_cnt[1] != CNT_STRONG_T) begin
                cnt_next = rd_cnt[1] + 2'd1;
            end
        end else if (rd_cnt[1] != CNT_STRONG_NT) begin
            cnt_next = rd_cnt[1] - 2'd1;
        end
    end

    bp_table #(
        .entry_t     (counter_t),
        .DEPTH_LOG2  (HW),
        .RESET_VALUE (CNT_WEAK_NT)
    ) u_pht_table (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rd_cnt),
        .wr_en_i   (train),
        .wr_idx_i  (rd_idx[1]),
        .wr_data_i (cnt_next)
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (train) begin
            ghr_q <= {ghr_q[HW-2:0], resolve_i.taken};
        end
    end

    assign taken_o = rd_cnt[0][1];
    assign ghr_o   = ghr_q;

endmodule

// ==== hdl/bp_table.sv ====
`timescale 1ns/1ps

module bp_table #(
    parameter type    entry_t     = logic,
    parameter int     DEPTH_LOG2  = 4,
    parameter entry_t RESET_VALUE = '0
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic [1:0][DEPTH_LOG2-1:0]  rd_idx_i,
    output entry_t [1:0]                rd_data_o,
    input  logic                        wr_en_i,
    input  logic [DEPTH_LOG2-1:0]       wr_idx_i,
    input  entry_t                      wr_data_i
);

    localparam int DEPTH    = 2 ** DEPTH_LOG2;
    localparam int RD_PORTS = 2;

    entry_t mem_q [DEPTH];

    // Port 0 serves the fetch lookup, port 1 the resolve side
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rd_data_o[p] = mem_q[rd_idx_i[p]];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= RESET_VALUE;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

// ==== hdl/bp_stage_pkg.sv ====
package bp_stage_pkg;

    // Same encoding as the branch and jump kinds of the later stages
    typedef enum logic [1:0] {
        RES_NONE = 2'b00,
        RES_COND = 2'b01,
        RES_JAL  = 2'b10,
        RES_JALR = 2'b11
    } resolve_kind_t;

    // Outcome of one branch, valid for the cycle its kind is not RES_NONE
    typedef struct packed {
        resolve_kind_t      kind;
        bp_store_pkg::pc_t  pc;
        bp_store_pkg::pc_t  target;
        logic               taken;
        logic               pred_taken;
        bp_store_pkg::ghr_t ghr;
    } resolve_t;

    // Prediction for the current fetch address
    typedef struct packed {
        logic               hit;
        logic               taken;
        bp_store_pkg::pc_t  target;
        bp_store_pkg::ghr_t ghr;
    } pred_t;

endpackage

// ==== hdl/bp_store_pkg.sv ====
`include "bp_cfg.svh"

package bp_store_pkg;

    // Fetch address
    typedef logic [`BP_XLEN-1:0] pc_t;

    // Global history, newest outcome in bit 0
    typedef logic [`BP_HISTORY_WIDTH-1:0] ghr_t;

    // 2-bit saturating counter, upper bit means predict taken
    typedef logic [1:0] counter_t;

    localparam counter_t CNT_STRONG_NT = 2'b00;
    localparam counter_t CNT_WEAK_NT   = 2'b01;
    localparam counter_t CNT_STRONG_T  = 2'b11;

    // PC bits above the BTB index and the byte offset
    typedef logic [`BP_XLEN-`BP_INDEX_WIDTH-3:0] btb_tag_t;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        pc_t      target;
    } btb_entry_t;

endpackage

// ==== hdl/bp_cfg.svh ====
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Fetch address width
`define BP_XLEN 32

// BTB index bits, taken from PC[INDEX+1:2]
`define BP_INDEX_WIDTH 10

// GHR length, also the PHT index width
`define BP_HISTORY_WIDTH 8

// First fetch address after reset
`define BP_RESET_PC 32'h0000_0000

`endif
